/* list.f */
verilog/dedekindPkg.sv
verilog/pipelineManager.sv
verilog/permuteCheck6.sv
verilog/termPipeline.sv
verilog/resultFifo.sv
verilog/openCLFullPipeline.sv
testbench/clockGen.sv
testbench/openCLFullPipeline_properties.sv
testbench/tbOpenCLFullPipeline.sv

/* testbench/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clock
);

    initial clock = 1'b0;

    always #20 clock = ~clock; // 40 ns period

endmodule

/* testbench/openCLFullPipeline_properties.sv */
`timescale 1ns/1ps

module openCLFullPipelineProperties
    import dedekindPkg::*;
(
    input logic                       clock,
    input logic                       resetn,
    input logic                       ovalid,
    input logic                       iready,
    input logic [63:0]                summedDataPcoeffCountOut,
    input logic [FIFO_COUNT_BITS-1:0] fillLevel
);

    int failures = 0;

    quietInReset: assert property (@(posedge clock) resetn |=> !ovalid)
        else begin
            failures++;
            $error("ovalid high while reset is applied");
        end

    // a stalled result must not change under the consumer
    heldWhileStalled: assert property (@(posedge clock) disable iff (resetn)
        ovalid && !iready |=> $stable(summedDataPcoeffCountOut))
        else begin
            failures++;
            $error("output word changed while stalled");
        end

    fillBounded: assert property (@(posedge clock) disable iff (resetn)
        fillLevel <= FIFO_COUNT_BITS'(FIFO_DEPTH))
        else begin
            failures++;
            $error("FIFO fill level above its depth");
        end

endmodule

bind openCLFullPipeline openCLFullPipelineProperties props (
    .clock                   (clock),
    .resetn                  (resetn),
    .ovalid                  (ovalid),
    .iready                  (iready),
    .summedDataPcoeffCountOut(summedDataPcoeffCountOut),
    .fillLevel               (fillLevel)
);

/* testbench/tbOpenCLFullPipeline.sv */
`timescale 1ns/1ps

module tbOpenCLFullPipeline
    import dedekindPkg::*;
();

    localparam int WAIT_LIMIT = 400; // cycles any single wait may take

    logic        clock;
    logic        resetn;
    logic        ivalid;
    logic        iready = 1'b0;
    logic        startNewTop;
    logic [63:0] botLower;
    logic [63:0] botUpper;
    logic        ovalid;
    logic        oready;
    logic [63:0] summedDataPcoeffCountOut;

    logic [31:0]           dataState  = 32'h7c2e;
    logic [31:0]           stallState = 32'h7c2e;
    logic [1:0]            stallMode  = 2'd0;     // 0 always ready, 1 random, 2 held off
    logic [FUNC_BITS-1:0]  modelTop   = '0;
    logic [INDEX_BITS-1:0] modelIndex = '0;
    logic [63:0]           expectQ [$];
    logic [63:0]           expected;
    logic                  lastAccepted;
    logic                  hung          = 1'b0;
    int                    receivedCount = 0;
    int                    mismatchCount = 0;
    int                    checkCount    = 0;
    int                    timeoutCount  = 0;

    clockGen clockSource (.clock(clock));

    openCLFullPipeline u_dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [FUNC_BITS-1:0] randomWord();
        logic [FUNC_BITS-1:0] w;
        for (int k = 0; k < FUNC_BITS / 32; k++) begin
            dataState = xorshift32(dataState);
            w         = {w[FUNC_BITS-33:0], dataState};
        end
        return w;
    endfunction

    // p counts ABC, ACB, BAC, BCA, CAB, CBA; a, b, c are the source variables of bits 4..6
    function automatic logic [FUNC_BITS-1:0] permuteFunc(input logic [FUNC_BITS-1:0] f,
                                                         input int p);
        logic [FUNC_BITS-1:0] r;
        logic [6:0]           i;
        logic [6:0]           j;
        int                   a;
        int                   b;
        a = p / 2;
        b = (p % 2 == 0) ? ((a == 0) ? 1 : 0) : ((a == 2) ? 1 : 2);
        for (int n = 0; n < FUNC_BITS; n++) begin
            i    = 7'(n);
            j    = i;
            j[4] = i[4 + a];
            j[5] = i[4 + b];
            j[6] = i[7 - a - b]; // the remaining variable
            r[n] = f[j];
        end
        return r;
    endfunction

    function automatic logic [63:0] expectedWord(input logic [FUNC_BITS-1:0]  top,
                                                 input logic [FUNC_BITS-1:0]  bot,
                                                 input logic [INDEX_BITS-1:0] index);
        logic [FUNC_BITS-1:0]  pb;
        logic [SUM_BITS-1:0]   sum;
        logic [COUNT_BITS-1:0] count;
        sum   = '0;
        count = '0;
        for (int p = 0; p < NUM_PERMS; p++) begin
            pb = permuteFunc(bot, p);
            if ((pb & ~top) == '0) begin
                count = count + 1'b1;
                sum   = sum + SUM_BITS'($countones(top & ~pb));
            end
        end
        return {index, 7'd0, count, sum};
    endfunction

    function automatic logic [FUNC_BITS-1:0] randomBot(input logic [FUNC_BITS-1:0] top);
        logic [FUNC_BITS-1:0] core;
        core = top;
        for (int p = 1; p < NUM_PERMS; p++) begin
            core = core & permuteFunc(top, p); // fits top under every permutation
        end
        dataState = xorshift32(dataState);
        case (dataState % 3)
            0:       return randomWord() & core;
            1:       return randomWord() & randomWord() & top;
            default: return randomWord(); // almost surely outside top
        endcase
    endfunction

    task automatic expectTrue(input logic cond, input string what);
        assert (cond) else begin
            checkCount++;
            $display("FAILED at %0t: %s", $time, what);
        end
    endtask

    task automatic reportTimeout(input string what);
        if (!hung) begin
            timeoutCount++;
            hung = 1'b1;
            $display("timeout at %0t: %s", $time, what);
        end
    endtask

    // offer one word until it is taken, modelling top and index as the DUT keeps them
    task automatic sendWord(input logic isTop, input logic [FUNC_BITS-1:0] data,
                            input int limit = WAIT_LIMIT);
        int waited;
        waited       = 0;
        lastAccepted = 1'b0;
        startNewTop          <= isTop;
        {botUpper, botLower} <= data;
        ivalid               <= 1'b1;
        while (!hung && !lastAccepted && waited < limit) begin
            @(posedge clock);
            waited++;
            lastAccepted = (oready === 1'b1); // ivalid was already high before this edge
        end
        if (lastAccepted && isTop) begin
            modelTop   = data;
            modelIndex = '0;
        end else if (lastAccepted) begin
            expectQ.push_back(expectedWord(modelTop, data, modelIndex));
            modelIndex = modelIndex + 1'b1;
        end else begin
            ivalid <= 1'b0;
            if (limit == WAIT_LIMIT) begin
                reportTimeout("oready never rose for a waiting word");
            end
        end
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        ivalid <= 1'b0;
        while (!hung && expectQ.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (expectQ.size() != 0) begin
            reportTimeout("results still missing after the stream ended");
        end
    endtask

    always @(posedge clock) begin
        stallState = xorshift32(stallState);
        iready    <= (stallMode == 2'd0) || (stallMode == 2'd1 && stallState[9]);
    end

    // scoreboard, one expected word per output handshake
    always @(posedge clock) begin
        if (!resetn && ovalid && iready) begin
            receivedCount++;
            assert (expectQ.size() != 0) else begin
                checkCount++;
                $display("result %h came out at %0t with nothing outstanding",
                         summedDataPcoeffCountOut, $time);
            end
            if (expectQ.size() != 0) begin
                expected = expectQ.pop_front();
                assert (summedDataPcoeffCountOut === expected) else begin
                    mismatchCount++;
                    $display("FAILED at %0t: result %h, expected %h", $time,
                             summedDataPcoeffCountOut, expected);
                end
            end
        end
    end

    initial begin
        int edges;
        int propertyFailures;
        resetn      = 1'b1;
        ivalid      = 1'b0;
        startNewTop = 1'b0;
        botLower    = '0;
        botUpper    = '0;
        repeat (4) @(posedge clock);
        resetn <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        expectTrue(oready === 1'b1, "oready not high after reset");
        expectTrue(ovalid === 1'b0, "ovalid not low after reset");
        @(posedge clock);
        sendWord(1'b1, randomWord() & ~FUNC_BITS'(1)); // index 0 stays put under all perms
        ivalid <= 1'b0;
        repeat (12) @(posedge clock);
        expectTrue(receivedCount == 0, "a top load alone produced a result");
        for (int n = 0; n < 40; n++) begin
            sendWord(1'b0, randomBot(modelTop));
        end
        sendWord(1'b0, FUNC_BITS'(1)); // bit 0 lies outside top for every permutation
        waitDrained();
        stallMode <= 2'd2;
        for (int n = 0; n < FIFO_DEPTH; n++) begin
            sendWord(1'b0, randomBot(modelTop));
        end
        sendWord(1'b0, randomBot(modelTop), 12);
        expectTrue(!lastAccepted && oready === 1'b0, "oready stayed high with FIFO and pipe full");
        stallMode <= 2'd1;
        for (int n = 0; n < 60; n++) begin
            sendWord(1'b0, randomBot(modelTop));
        end
        sendWord(1'b1, randomWord()); // new top while results are still in flight
        for (int n = 0; n < 20; n++) begin
            sendWord(1'b0, randomBot(modelTop));
        end
        waitDrained();
        stallMode <= 2'd0;
        ivalid    <= 1'b0;
        repeat (3) @(posedge clock);
        sendWord(1'b0, randomBot(modelTop));
        ivalid <= 1'b0;
        edges = 0;
        do begin
            @(posedge clock);
            edges++;
            @(negedge clock);
        end while (ovalid !== 1'b1 && edges < WAIT_LIMIT);
        expectTrue(edges == 5, "single bot not presented five cycles after acceptance");
        @(posedge clock);
        waitDrained();
        propertyFailures = u_dut.props.failures;
        $display("errors: %0d mismatches, %0d failed checks, %0d timeouts, %0d property failures",
                 mismatchCount, checkCount, timeoutCount, propertyFailures);
        if (mismatchCount + checkCount + timeoutCount + propertyFailures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog/dedekindPkg.sv */
package dedekindPkg;

    localparam int FUNC_BITS       = 128; // one monotone function of 7 variables
    localparam int NUM_PERMS       = 6;   // permutations of A, B, C
    localparam int INDEX_BITS      = 16;
    localparam int SUM_BITS        = 38;
    localparam int COUNT_BITS      = 3;
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_COUNT_BITS = 5;   // holds 0..FIFO_DEPTH
    localparam int PIPE_LATENCY    = 4;   // accept edge to FIFO write edge

    // bot as handed from the manager to the permutation stage
    typedef struct packed {
        logic [FUNC_BITS-1:0]  bot;
        logic [INDEX_BITS-1:0] botIndex;
    } botJob_t;

    // per permutation: gap = top & ~permutedBot, valid when permutedBot is inside top
    typedef struct packed {
        logic [NUM_PERMS-1:0][FUNC_BITS-1:0] gap;
        logic [NUM_PERMS-1:0]                validPerms;
        logic [INDEX_BITS-1:0]               botIndex;
    } checkedBot_t;

    // field order matches the output word from bit 63 down, minus the zero pad
    typedef struct packed {
        logic [INDEX_BITS-1:0] botIndex;
        logic [COUNT_BITS-1:0] pcoeffCount;
        logic [SUM_BITS-1:0]   summedData;
    } pipeResult_t;

endpackage

/* verilog/openCLFullPipeline.sv */
`timescale 1ns/1ps

module openCLFullPipeline
    import dedekindPkg::*;
(
    input  logic        clock,
    input  logic        resetn,
    input  logic        ivalid,
    input  logic        iready,
    input  logic        startNewTop,
    input  logic [63:0] botLower,
    input  logic [63:0] botUpper,
    output logic        ovalid,
    output logic        oready,
    output logic [63:0] summedDataPcoeffCountOut
);

    logic [FUNC_BITS-1:0]       word;      // top or bot as startNewTop selects
    logic [FUNC_BITS-1:0]       topReg;
    botJob_t                    job;
    logic                       push;
    checkedBot_t                checked;
    pipeResult_t                result;
    pipeResult_t                dout;
    logic [FIFO_COUNT_BITS-1:0] fillLevel;

    assign word = {botUpper, botLower};

    pipelineManager pipelineMngr (
        .clock      (clock),
        .resetn     (resetn),
        .ivalid     (ivalid),
        .startNewTop(startNewTop),
        .word       (word),
        .fillLevel  (fillLevel),
        .oready     (oready),
        .topReg     (topReg),
        .job        (job),
        .issue      (),
        .push       (push)
    );

    permuteCheck6 permuteChecker (
        .clock  (clock),
        .topReg (topReg),
        .job    (job),
        .checked(checked)
    );

    termPipeline terms (
        .clock  (clock),
        .checked(checked),
        .result (result)
    );

    resultFifo resultsBuf (
        .clock    (clock),
        .resetn   (resetn),
        .push     (push),
        .din      (result),
        .iready   (iready),
        .ovalid   (ovalid),
        .dout     (dout),
        .fillLevel(fillLevel)
    );

    // index on top, then a zero pad, pcoeffCount and summedData
    assign summedDataPcoeffCountOut = {dout.botIndex,
                                       {(64 - INDEX_BITS - COUNT_BITS - SUM_BITS){1'b0}},
                                       dout.pcoeffCount,
                                       dout.summedData};

endmodule

/* verilog/permuteCheck6.sv */
`timescale 1ns/1ps

module permuteCheck6
    import dedekindPkg::*;
(
    input  logic                 clock,
    input  logic [FUNC_BITS-1:0] topReg,
    input  botJob_t              job,
    output checkedBot_t          checked
);

    logic [NUM_PERMS-1:0][FUNC_BITS-1:0] permuted;

    // Variables A, B, C sit on index bits 4, 5, 6. Each permutation only
    // reorders those three bits of the truth-table index, so with a constant
    // p the loop collapses into plain wiring.
    function automatic logic [FUNC_BITS-1:0] permuteBot(
        input logic [FUNC_BITS-1:0] f,
        input int                   p
    );
        logic [FUNC_BITS-1:0] r;
        logic [6:0]           idx;
        logic [6:0]           src;
        for (int i = 0; i < FUNC_BITS; i++) begin
            idx = 7'(i);
            src = idx;
            case (p)
                0:       src[6:4] = {idx[6], idx[5], idx[4]}; // ABC
                1:       src[6:4] = {idx[5], idx[6], idx[4]}; // ACB, swap B and C
                2:       src[6:4] = {idx[6], idx[4], idx[5]}; // BAC, swap A and B
                3:       src[6:4] = {idx[4], idx[6], idx[5]}; // BCA
                4:       src[6:4] = {idx[5], idx[4], idx[6]}; // CAB
                default: src[6:4] = {idx[4], idx[5], idx[6]}; // CBA, swap A and C
            endcase
            r[i] = f[src];
        end
        return r;
    endfunction

    always_comb begin
        for (int p = 0; p < NUM_PERMS; p++) begin
            permuted[p] = permuteBot(job.bot, p);
        end
    end

    always_ff @(posedge clock) begin
        for (int p = 0; p < NUM_PERMS; p++) begin
            checked.gap[p]        <= topReg & ~permuted[p];
            checked.validPerms[p] <= ~|(permuted[p] & ~topReg); // subset of top
        end
        checked.botIndex <= job.botIndex;
    end

endmodule

/* verilog/pipelineManager.sv */
`timescale 1ns/1ps

module pipelineManager
    import dedekindPkg::*;
(
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       ivalid,
    input  logic                       startNewTop,
    input  logic [FUNC_BITS-1:0]       word,
    input  logic [FIFO_COUNT_BITS-1:0] fillLevel,
    output logic                       oready,
    output logic [FUNC_BITS-1:0]       topReg,
    output botJob_t                    job,
    output logic                       issue,
    output logic                       push
);

    logic                       accept;
    logic [PIPE_LATENCY-1:0]    inFlight;    // one bit per occupied pipeline stage
    logic [INDEX_BITS-1:0]      botIndex;
    logic [FIFO_COUNT_BITS:0]   committed;   // fifo entries plus bots still in the pipe

    assign accept = ivalid && oready;
    assign issue  = accept && !startNewTop; // top loads never enter the pipe
    assign push   = inFlight[PIPE_LATENCY-1];

    // the datapath samples the input word directly, index travels with it
    assign job = '{bot: word, botIndex: botIndex};

    // Upper bound on what the FIFO may have to hold after this edge. A pop in
    // this cycle is ignored, so the bound is pessimistic by at most one.
    always_comb begin
        committed = (FIFO_COUNT_BITS + 1)'(fillLevel) + (FIFO_COUNT_BITS + 1)'(issue);
        for (int i = 0; i < PIPE_LATENCY; i++) begin
            committed = committed + (FIFO_COUNT_BITS + 1)'(inFlight[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (resetn) begin
            inFlight <= '0;
            oready   <= 1'b0;
        end else begin
            inFlight <= {inFlight[PIPE_LATENCY-2:0], issue};
            oready   <= committed < (FIFO_COUNT_BITS + 1)'(FIFO_DEPTH); // room for one more
        end
    end

    always_ff @(posedge clock) begin
        if (resetn) begin
            topReg   <= '0;
            botIndex <= '0;
        end else if (accept && startNewTop) begin
            topReg   <= word;
            botIndex <= '0; // numbering restarts per top
        end else if (issue) begin
            botIndex <= botIndex + 1'b1;
        end
    end

endmodule

/* verilog/resultFifo.sv */
`timescale 1ns/1ps

module resultFifo
    import dedekindPkg::*;
(
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       push,
    input  pipeResult_t                din,
    input  logic                       iready,
    output logic                       ovalid,
    output pipeResult_t                dout,
    output logic [FIFO_COUNT_BITS-1:0] fillLevel
);

    pipeResult_t                mem [FIFO_DEPTH];
    logic [FIFO_COUNT_BITS-2:0] wrPtr;    // wraps at FIFO_DEPTH
    logic [FIFO_COUNT_BITS-2:0] rdPtr;
    logic [FIFO_COUNT_BITS-1:0] memCount; // entries in mem, not counting dout
    logic                       pop;
    logic                       load;

    assign pop  = ovalid && iready;
    // refill the output register whenever it is empty or being taken
    assign load = (memCount != '0) && (!ovalid || pop);

    assign fillLevel = memCount + FIFO_COUNT_BITS'(ovalid);

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wrPtr] <= din;
        end
        if (load) begin
            dout <= mem[rdPtr];
        end
    end

    always_ff @(posedge clock) begin
        if (resetn) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            memCount <= '0;
            ovalid   <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (load) begin
                rdPtr <= rdPtr + 1'b1;
            end
            memCount <= memCount + FIFO_COUNT_BITS'(push) - FIFO_COUNT_BITS'(load);
            if (load) begin
                ovalid <= 1'b1;
            end else if (pop) begin
                ovalid <= 1'b0; // last word left
            end
        end
    end

endmodule

/* verilog/termPipeline.sv */
`timescale 1ns/1ps

module termPipeline
    import dedekindPkg::*;
(
    input  logic        clock,
    input  checkedBot_t checked,
    output pipeResult_t result
);

    logic [NUM_PERMS-1:0][7:0]     s1Count;   // popcount of each gap, max 128
    logic [NUM_PERMS-1:0]          s1Valid;
    logic [INDEX_BITS-1:0]         s1Index;

    logic [NUM_PERMS-1:0][7:0]     masked;
    logic [NUM_PERMS/2-1:0][8:0]   pairSum;
    logic [COUNT_BITS-1:0]         validCount;

    logic [NUM_PERMS/2-1:0][8:0]   s2Pair;
    logic [COUNT_BITS-1:0]         s2Count;
    logic [INDEX_BITS-1:0]         s2Index;

    logic [SUM_BITS-1:0]           total;

    function automatic logic [7:0] popcount(input logic [FUNC_BITS-1:0] v);
        logic [7:0] n;
        n = '0;
        for (int i = 0; i < FUNC_BITS; i++) begin
            n = n + 8'(v[i]);
        end
        return n;
    endfunction

    // stage 1
    always_ff @(posedge clock) begin
        for (int p = 0; p < NUM_PERMS; p++) begin
            s1Count[p] <= popcount(checked.gap[p]);
        end
        s1Valid <= checked.validPerms;
        s1Index <= checked.botIndex;
    end

    // stage 2: drop the terms of permutations that are not below top
    always_comb begin
        for (int p = 0; p < NUM_PERMS; p++) begin
            masked[p] = s1Valid[p] ? s1Count[p] : 8'd0;
        end
        for (int k = 0; k < NUM_PERMS / 2; k++) begin
            pairSum[k] = {1'b0, masked[2*k]} + {1'b0, masked[2*k+1]};
        end
        validCount = '0;
        for (int p = 0; p < NUM_PERMS; p++) begin
            validCount = validCount + COUNT_BITS'(s1Valid[p]); // at most 6
        end
    end

    always_ff @(posedge clock) begin
        s2Pair  <= pairSum;
        s2Count <= validCount;
        s2Index <= s1Index;
    end

    // stage 3
    always_comb begin
        total = '0;
        for (int k = 0; k < NUM_PERMS / 2; k++) begin
            total = total + SUM_BITS'(s2Pair[k]);
        end
    end

    always_ff @(posedge clock) begin
        result.summedData  <= total;
        result.pcoeffCount <= s2Count;
        result.botIndex    <= s2Index;
    end

endmodule
